// ==== flist.f ====
isa_pkg.sv
alu_pkg.sv
alu_decode.sv
op_fifo.sv
alu_exec.sv
alu_top.sv
tb_clock_gen.sv
alu_top_chk.sv
alu_top_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= alu_top_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== alu_top_tb.sv ====
`timescale 1ns/1ps

module alu_top_tb;

  import isa_pkg::*;
  import alu_pkg::*;

  localparam int unsigned SEED = 32'h7648_eb44;

  typedef struct {
    string  name;
    instr_t instr;
    word_t  rs;
    word_t  rt;
    word_t  exp;
    logic   exp_ill;
  } test_rec_t;

  logic        clk;
  logic        reset_n;
  logic        in_valid;
  logic        in_ready;
  instr_t      instr;
  word_t       rs_val;
  word_t       rt_val;
  logic        res_valid;
  logic        res_ready = 1'b0;
  word_t       result;
  logic        zero;
  logic        illegal;

  test_rec_t   tests[$];
  int          cycles = 0;
  int          limit;
  int          n_done;
  int          n_pass;
  int          n_fail;
  logic        test_bad;

  tb_clock_gen u_clk (.clk(clk));

  alu_top dut0 (
    .clk       (clk),
    .reset_n   (reset_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .instr     (instr),
    .rs_val    (rs_val),
    .rt_val    (rt_val),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .result    (result),
    .zero      (zero),
    .illegal   (illegal)
  );

  bind alu_top alu_top_chk u_chk (
    .clk       (clk),
    .reset_n   (reset_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .instr     (instr),
    .rs_val    (rs_val),
    .rt_val    (rt_val),
    .dec_valid (dec_valid),
    .dec_ready (dec_ready),
    .dec_op    (dec_op),
    .dec_a     (dec_a),
    .dec_b     (dec_b),
    .dec_shamt (dec_shamt),
    .ex_valid  (ex_valid),
    .ex_ready  (ex_ready),
    .ex_op     (ex_op),
    .ex_a      (ex_a),
    .ex_b      (ex_b),
    .ex_shamt  (ex_shamt),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .result    (result),
    .zero      (zero),
    .illegal   (illegal)
  );

  function automatic instr_t r_instr(funct_t fn, shamt_t sa);
    return {OPC_SPECIAL, 15'd0, sa, fn};
  endfunction

  function automatic instr_t i_instr(opcode_t opc, logic [4:0] rt, logic [15:0] imm);
    return {opc, 5'd0, rt, imm};
  endfunction

  task automatic add_test(string name, instr_t ins, word_t rs, word_t rt, word_t exp,
                          logic ill);
    tests.push_back('{name, ins, rs, rt, exp, ill});
  endtask

  task automatic build_table();
    add_test("and", r_instr(FN_AND, 5'd0), 32'hf0f0_1234, 32'h0ff0_ffff, 32'h00f0_1234, 1'b0);
    add_test("or", r_instr(FN_OR, 5'd0), 32'hf000_0000, 32'h0000_000f, 32'hf000_000f, 1'b0);
    add_test("xor", r_instr(FN_XOR, 5'd0), 32'hffff_0000, 32'hffff_ffff, 32'h0000_ffff, 1'b0);
    add_test("addu_wrap", r_instr(FN_ADDU, 5'd0), 32'hffff_ffff, 32'h2, 32'h1, 1'b0);
    add_test("addu_zero", r_instr(FN_ADDU, 5'd0), 32'hffff_fff0, 32'h10, 32'h0, 1'b0);
    add_test("subu", r_instr(FN_SUBU, 5'd0), 32'h5, 32'h7, 32'hffff_fffe, 1'b0);
    add_test("addiu_neg", i_instr(OPC_ADDIU, 5'd0, 16'hffff), 32'h10, 32'h0, 32'hf, 1'b0);
    add_test("andi_zext", i_instr(OPC_ANDI, 5'd0, 16'h8001), 32'hffff_ffff, 32'h0,
             32'h0000_8001, 1'b0);
    add_test("ori_zext", i_instr(OPC_ORI, 5'd0, 16'h8000), 32'h1, 32'h0, 32'h0000_8001, 1'b0);
    add_test("xori_zext", i_instr(OPC_XORI, 5'd0, 16'hffff), 32'hffff_ffff, 32'h0,
             32'hffff_0000, 1'b0);
    // Shifts, LUI and store merges
    add_test("sll", r_instr(FN_SLL, 5'd4), 32'h0, 32'h0000_00ff, 32'h0000_0ff0, 1'b0);
    add_test("srl", r_instr(FN_SRL, 5'd8), 32'h0, 32'h8000_0000, 32'h0080_0000, 1'b0);
    add_test("sra", r_instr(FN_SRA, 5'd8), 32'h0, 32'h8000_0000, 32'hff80_0000, 1'b0);
    add_test("sllv", r_instr(FN_SLLV, 5'd0), 32'h23, 32'h1, 32'h8, 1'b0);
    add_test("srlv", r_instr(FN_SRLV, 5'd0), 32'h24, 32'hf000_0000, 32'h0f00_0000, 1'b0);
    add_test("srav", r_instr(FN_SRAV, 5'd0), 32'h4, 32'hf000_0000, 32'hff00_0000, 1'b0);
    add_test("lui", i_instr(OPC_LUI, 5'd0, 16'h1234), 32'h0, 32'h0, 32'h1234_0000, 1'b0);
    add_test("sb", i_instr(OPC_SB, 5'd0, 16'h5678), 32'h1122_33ab, 32'h0, 32'h0000_56ab, 1'b0);
    add_test("sh", i_instr(OPC_SH, 5'd0, 16'h8000), 32'h0000_beef, 32'h0, 32'hffff_beef, 1'b0);
    // Compares and branches where result 0 means taken
    add_test("slt", r_instr(FN_SLT, 5'd0), 32'hffff_ffff, 32'h1, 32'h1, 1'b0);
    add_test("sltu", r_instr(FN_SLTU, 5'd0), 32'hffff_ffff, 32'h1, 32'h0, 1'b0);
    add_test("slti", i_instr(OPC_SLTI, 5'd0, 16'hffff), 32'h1, 32'h0, 32'h0, 1'b0);
    add_test("sltiu", i_instr(OPC_SLTIU, 5'd0, 16'hffff), 32'h1, 32'h0, 32'h1, 1'b0);
    add_test("beq_equal", i_instr(OPC_BEQ, 5'd0, 16'h0), 32'h5, 32'h5, 32'h1, 1'b0);
    add_test("bne_taken", i_instr(OPC_BNE, 5'd0, 16'h0), 32'h5, 32'h6, 32'h0, 1'b0);
    add_test("bltz_taken", i_instr(OPC_REGIMM, RT_BLTZ, 16'h0), 32'h8000_0000, 32'h0, 32'h0,
             1'b0);
    add_test("bgez_not", i_instr(OPC_REGIMM, RT_BGEZ, 16'h0), 32'h8000_0000, 32'h0, 32'h1,
             1'b0);
    add_test("blez_taken", i_instr(OPC_BLEZ, 5'd0, 16'h0), 32'h0, 32'h0, 32'h0, 1'b0);
    add_test("bgtz_not", i_instr(OPC_BGTZ, 5'd0, 16'h0), 32'h0, 32'h0, 32'h1, 1'b0);
    add_test("jr", r_instr(FN_JR, 5'd0), 32'h0000_4000, 32'h0, 32'h0, 1'b0);
    // HI/LO producers and their read-backs
    add_test("mult", r_instr(FN_MULT, 5'd0), 32'hffff_fffe, 32'h3, 32'h0, 1'b0);
    add_test("mult_hi", r_instr(FN_MFHI, 5'd0), 32'h0, 32'h0, 32'hffff_ffff, 1'b0);
    add_test("mult_lo", r_instr(FN_MFLO, 5'd0), 32'h0, 32'h0, 32'hffff_fffa, 1'b0);
    add_test("multu", r_instr(FN_MULTU, 5'd0), 32'hffff_ffff, 32'hffff_ffff, 32'h0, 1'b0);
    add_test("multu_hi", r_instr(FN_MFHI, 5'd0), 32'h0, 32'h0, 32'hffff_fffe, 1'b0);
    add_test("multu_lo", r_instr(FN_MFLO, 5'd0), 32'h0, 32'h0, 32'h0000_0001, 1'b0);
    add_test("div", r_instr(FN_DIV, 5'd0), 32'hffff_fff9, 32'h2, 32'h0, 1'b0);
    add_test("div_hi", r_instr(FN_MFHI, 5'd0), 32'h0, 32'h0, 32'hffff_ffff, 1'b0);
    add_test("div_lo", r_instr(FN_MFLO, 5'd0), 32'h0, 32'h0, 32'hffff_fffd, 1'b0);
    add_test("divu_by0", r_instr(FN_DIVU, 5'd0), 32'h7, 32'h0, 32'h0, 1'b0);
    add_test("divu_hi", r_instr(FN_MFHI, 5'd0), 32'h0, 32'h0, 32'h7, 1'b0);
    add_test("divu_lo", r_instr(FN_MFLO, 5'd0), 32'h0, 32'h0, 32'hffff_ffff, 1'b0);
    add_test("mthi", r_instr(FN_MTHI, 5'd0), 32'hcafe_0001, 32'h0, 32'h0, 1'b0);
    add_test("mtlo", r_instr(FN_MTLO, 5'd0), 32'h0000_beef, 32'h0, 32'h0, 1'b0);
    // Illegal encodings between the moves and their reads
    add_test("bad_opcode", i_instr(6'h3f, 5'd0, 16'h1234), 32'h1, 32'h2, 32'h0, 1'b1);
    add_test("bad_funct", r_instr(6'h3f, 5'd0), 32'h1, 32'h2, 32'h0, 1'b1);
    add_test("bad_regimm", i_instr(OPC_REGIMM, 5'h10, 16'h0), 32'h1, 32'h0, 32'h0, 1'b1);
    add_test("mt_hi", r_instr(FN_MFHI, 5'd0), 32'h0, 32'h0, 32'hcafe_0001, 1'b0);
    add_test("mt_lo", r_instr(FN_MFLO, 5'd0), 32'h0, 32'h0, 32'h0000_beef, 1'b0);
    add_test("addu_after", r_instr(FN_ADDU, 5'd0), 32'h1, 32'h2, 32'h3, 1'b0);
  endtask

  task automatic check_word(string test_name, string what, word_t expected, word_t actual);
    if (actual !== expected) begin
      $display("Mismatch %s %s: expected %h, actual %h", test_name, what, expected, actual);
      test_bad = 1'b1;
    end
  endtask

  task automatic check_flag(string test_name, string what, logic expected, logic actual);
    if (actual !== expected) begin
      $display("Mismatch %s %s: expected %b, actual %b", test_name, what, expected, actual);
      test_bad = 1'b1;
    end
  endtask

  task automatic drive_all();
    logic taken;
    for (int i = 0; i < tests.size(); i++) begin
      in_valid <= 1'b1;
      instr    <= tests[i].instr;
      rs_val   <= tests[i].rs;
      rt_val   <= tests[i].rt;
      taken = 1'b0;
      while (!taken) begin
        @(negedge clk);
        taken = in_ready;  // Stable mid-cycle
        @(posedge clk);
      end
    end
    in_valid <= 1'b0;
  endtask

  always @(posedge clk) begin
    cycles    <= cycles + 1;
    res_ready <= ($urandom % 32'd3) != 32'd0;  // Stall about one cycle in three
  end

  // A beat seen at the falling edge transfers on the next rising edge
  always @(negedge clk) begin
    if (reset_n && res_valid && res_ready) begin
      if (n_done >= tests.size()) begin
        $display("Extra result beat arrived after every test was matched");
        n_fail++;
      end else begin
        test_bad = 1'b0;
        check_word(tests[n_done].name, "result", tests[n_done].exp, result);
        check_flag(tests[n_done].name, "zero", tests[n_done].exp == '0, zero);
        check_flag(tests[n_done].name, "illegal", tests[n_done].exp_ill, illegal);
        if (test_bad) begin
          n_fail++;
          $display("test %0d %s: error", n_done, tests[n_done].name);
        end else begin
          n_pass++;
          $display("test %0d %s: ok", n_done, tests[n_done].name);
        end
        n_done++;
      end
    end
  end

  initial begin
    reset_n  = 1'b0;
    in_valid = 1'b0;
    instr    = '0;
    rs_val   = '0;
    rt_val   = '0;
    n_done   = 0;
    n_pass   = 0;
    n_fail   = 0;
    test_bad = 1'b0;
    void'($urandom(SEED));
    build_table();
    limit = tests.size() * 20 + 100;
    repeat (5) @(posedge clk);
    reset_n <= 1'b1;
    fork
      drive_all();
    join_none
    while (n_done < tests.size() && cycles < limit) @(posedge clk);
    if (n_done < tests.size()) begin
      $display("Timeout: results stopped arriving after %0d of %0d tests",
               n_done, tests.size());
    end else begin
      repeat (20) @(posedge clk);  // Catch duplicate beats
    end
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d missing",
             tests.size(), n_pass, n_fail, tests.size() - n_done);
    if (n_fail == 0 && n_done == tests.size()) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== alu_top_chk.sv ====
`timescale 1ns/1ps

module alu_top_chk (
  input logic             clk,
  input logic             reset_n,
  input logic             in_valid,
  input logic             in_ready,
  input isa_pkg::instr_t  instr,
  input alu_pkg::word_t   rs_val,
  input alu_pkg::word_t   rt_val,
  input logic             dec_valid,
  input logic             dec_ready,
  input alu_pkg::alu_op_e dec_op,
  input alu_pkg::word_t   dec_a,
  input alu_pkg::word_t   dec_b,
  input alu_pkg::shamt_t  dec_shamt,
  input logic             ex_valid,
  input logic             ex_ready,
  input alu_pkg::alu_op_e ex_op,
  input alu_pkg::word_t   ex_a,
  input alu_pkg::word_t   ex_b,
  input alu_pkg::shamt_t  ex_shamt,
  input logic             res_valid,
  input logic             res_ready,
  input alu_pkg::word_t   result,
  input logic             zero,
  input logic             illegal
);

  // A stalled beat keeps valid and payload until it transfers
  in_hold: assert property (@(posedge clk) disable iff (!reset_n)
    in_valid && !in_ready |=> in_valid && $stable({instr, rs_val, rt_val}))
    else $error("Input beat dropped or changed while stalled");

  dec_hold: assert property (@(posedge clk) disable iff (!reset_n)
    dec_valid && !dec_ready |=> dec_valid && $stable({dec_op, dec_a, dec_b, dec_shamt}))
    else $error("Decode beat dropped or changed while stalled");

  ex_hold: assert property (@(posedge clk) disable iff (!reset_n)
    ex_valid && !ex_ready |=> ex_valid && $stable({ex_op, ex_a, ex_b, ex_shamt}))
    else $error("FIFO head dropped or changed while stalled");

  res_hold: assert property (@(posedge clk) disable iff (!reset_n)
    res_valid && !res_ready |=> res_valid && $stable({result, zero, illegal}))
    else $error("Result beat dropped or changed while stalled");

  // Nothing valid right out of reset
  reset_quiet: assert property (@(posedge clk)
    !reset_n |=> !in_ready && !dec_valid && !ex_valid && !res_valid)
    else $error("Handshake output high in the cycle after reset");

  zero_flag: assert property (@(posedge clk) disable iff (!reset_n)
    res_valid |-> (zero == (result == '0)))
    else $error("Zero flag disagrees with result");

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int HALF_NS = 4  // 8 ns period
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(HALF_NS) clk = ~clk;
  end

endmodule

// ==== alu_top.sv ====
`timescale 1ns/1ps

module alu_top (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            in_valid,
  output logic            in_ready,
  input  isa_pkg::instr_t instr,
  input  alu_pkg::word_t  rs_val,
  input  alu_pkg::word_t  rt_val,
  output logic            res_valid,
  input  logic            res_ready,
  output alu_pkg::word_t  result,
  output logic            zero,
  output logic            illegal
);

  import alu_pkg::*;

  // Decode to buffer
  logic    dec_valid, dec_ready;
  alu_op_e dec_op;
  word_t   dec_a, dec_b;
  shamt_t  dec_shamt;

  // Buffer to execute
  logic    ex_valid, ex_ready;
  alu_op_e ex_op;
  word_t   ex_a, ex_b;
  shamt_t  ex_shamt;

  alu_decode u_decode (
    .clk       (clk),
    .reset_n   (reset_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .instr     (instr),
    .rs_val    (rs_val),
    .rt_val    (rt_val),
    .dec_valid (dec_valid),
    .dec_ready (dec_ready),
    .dec_op    (dec_op),
    .dec_a     (dec_a),
    .dec_b     (dec_b),
    .dec_shamt (dec_shamt)
  );

  op_fifo u_fifo (
    .clk      (clk),
    .reset_n  (reset_n),
    .wr_valid (dec_valid),
    .wr_ready (dec_ready),
    .wr_op    (dec_op),
    .wr_a     (dec_a),
    .wr_b     (dec_b),
    .wr_shamt (dec_shamt),
    .rd_valid (ex_valid),
    .rd_ready (ex_ready),
    .rd_op    (ex_op),
    .rd_a     (ex_a),
    .rd_b     (ex_b),
    .rd_shamt (ex_shamt)
  );

  alu_exec u_exec (
    .clk       (clk),
    .reset_n   (reset_n),
    .ex_valid  (ex_valid),
    .ex_ready  (ex_ready),
    .ex_op     (ex_op),
    .ex_a      (ex_a),
    .ex_b      (ex_b),
    .ex_shamt  (ex_shamt),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .result    (result),
    .zero      (zero),
    .illegal   (illegal)
  );

endmodule

// ==== alu_exec.sv ====
`timescale 1ns/1ps

module alu_exec (
  input  logic             clk,
  input  logic             reset_n,
  input  logic             ex_valid,
  output logic             ex_ready,
  input  alu_pkg::alu_op_e ex_op,
  input  alu_pkg::word_t   ex_a,
  input  alu_pkg::word_t   ex_b,
  input  alu_pkg::shamt_t  ex_shamt,
  output logic             res_valid,
  input  logic             res_ready,
  output alu_pkg::word_t   result,
  output logic             zero,
  output logic             illegal
);

  import alu_pkg::*;

  word_t  hi, lo;
  logic   ex_fire;
  logic   is_signed;   // MULT or DIV
  logic   a_neg, b_neg;
  word_t  mag_a, mag_b;
  dword_t prod_mag, prod;
  word_t  quot, rem;
  word_t  y;
  logic   ill;

  assign ex_ready = !res_valid || res_ready;
  assign ex_fire  = ex_valid && ex_ready;

  // Signed forms run on magnitudes and fix the sign afterwards
  assign is_signed = (ex_op == OP_MULT) || (ex_op == OP_DIV);
  assign a_neg     = is_signed && ex_a[31];
  assign b_neg     = is_signed && ex_b[31];
  assign mag_a     = a_neg ? -ex_a : ex_a;
  assign mag_b     = b_neg ? -ex_b : ex_b;

  assign prod_mag = dword_t'(mag_a) * dword_t'(mag_b);
  assign prod     = (a_neg ^ b_neg) ? -prod_mag : prod_mag;

  always_comb begin
    if (mag_b == '0) begin
      quot = '1;   // Divide by zero
      rem  = ex_a;
    end else begin
      quot = (a_neg ^ b_neg) ? -(mag_a / mag_b) : (mag_a / mag_b); // Truncates to zero
      rem  = a_neg ? -(mag_a % mag_b) : (mag_a % mag_b);           // Sign of dividend
    end
  end

  always_comb begin
    y   = '0;
    ill = 1'b0;
    case (ex_op)
      OP_AND:   y = ex_a & ex_b;
      OP_OR:    y = ex_a | ex_b;
      OP_XOR:   y = ex_a ^ ex_b;
      OP_ADDU:  y = ex_a + ex_b;  // Wraps without a trap
      OP_SUBU:  y = ex_a - ex_b;
      OP_SLTU:  y = {31'b0, ex_a < ex_b};
      OP_SLT:   y = {31'b0, $signed(ex_a) < $signed(ex_b)};
      OP_SLL:   y = ex_b << ex_shamt;
      OP_SLLV:  y = ex_b << ex_a[4:0];
      OP_SRA:   y = word_t'($signed(ex_b) >>> ex_shamt);
      OP_SRL:   y = ex_b >> ex_shamt;
      OP_SRAV:  y = word_t'($signed(ex_b) >>> ex_a[4:0]);
      OP_SRLV:  y = ex_b >> ex_a[4:0];
      OP_MULT, OP_MULTU, OP_DIV, OP_DIVU,
      OP_MTHI, OP_MTLO: y = '0;  // Only HI/LO change
      // Branches give 0 when taken
      OP_BLTZ:  y = ex_a[31] ? 32'd0 : 32'd1;
      OP_BGTZ:  y = (!ex_a[31] && ex_a != '0) ? 32'd0 : 32'd1;
      OP_BGEZ:  y = !ex_a[31] ? 32'd0 : 32'd1;
      OP_BNE:   y = (ex_a != ex_b) ? 32'd0 : 32'd1;
      OP_BLEZ:  y = (ex_a[31] || ex_a == '0) ? 32'd0 : 32'd1;
      OP_JR:    y = 32'd0;       // Register jump is always taken
      OP_LUI:   y = {ex_b[15:0], 16'h0000};
      OP_MFHI:  y = hi;
      OP_MFLO:  y = lo;
      OP_SB:    y = {ex_b[31:8], ex_a[7:0]};
      OP_SH:    y = {ex_b[31:16], ex_a[15:0]};
      default: begin
        y   = '0;
        ill = 1'b1;
      end
    endcase
  end

  // HI/LO written on the accepting edge, visible to the next operation
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      hi <= '0;
      lo <= '0;
    end else if (ex_fire) begin
      case (ex_op)
        OP_MULT, OP_MULTU: begin
          hi <= prod[63:32];
          lo <= prod[31:0];
        end
        OP_DIV, OP_DIVU: begin
          hi <= rem;
          lo <= quot;
        end
        OP_MTHI: hi <= ex_a;
        OP_MTLO: lo <= ex_a;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) res_valid <= 1'b0;
    else if (ex_fire) res_valid <= 1'b1;
    else if (res_ready) res_valid <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (ex_fire) begin  // Held while stalled
      result  <= y;
      zero    <= (y == '0);
      illegal <= ill;
    end
  end

endmodule

// ==== op_fifo.sv ====
`timescale 1ns/1ps

module op_fifo (
  input  logic             clk,
  input  logic             reset_n,
  input  logic             wr_valid,
  output logic             wr_ready,
  input  alu_pkg::alu_op_e wr_op,
  input  alu_pkg::word_t   wr_a,
  input  alu_pkg::word_t   wr_b,
  input  alu_pkg::shamt_t  wr_shamt,
  output logic             rd_valid,
  input  logic             rd_ready,
  output alu_pkg::alu_op_e rd_op,
  output alu_pkg::word_t   rd_a,
  output alu_pkg::word_t   rd_b,
  output alu_pkg::shamt_t  rd_shamt
);

  import alu_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  alu_op_e    op_mem    [FIFO_DEPTH];
  word_t      a_mem     [FIFO_DEPTH];
  word_t      b_mem     [FIFO_DEPTH];
  shamt_t     shamt_mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic       full;
  logic       wr_fire;
  logic       rd_fire;

  assign full     = (count == CNT_W'(FIFO_DEPTH));
  assign rd_valid = (count != '0);
  assign wr_ready = !full || rd_ready; // Full slot frees on the same edge
  assign wr_fire  = wr_valid && wr_ready;
  assign rd_fire  = rd_valid && rd_ready;

  assign rd_op    = op_mem[rd_ptr];   // Head of queue
  assign rd_a     = a_mem[rd_ptr];
  assign rd_b     = b_mem[rd_ptr];
  assign rd_shamt = shamt_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_fire) wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two
      if (rd_fire) rd_ptr <= rd_ptr + 1'b1;
      if (wr_fire && !rd_fire) count <= count + 1'b1;
      else if (rd_fire && !wr_fire) count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      op_mem[wr_ptr]    <= wr_op;
      a_mem[wr_ptr]     <= wr_a;
      b_mem[wr_ptr]     <= wr_b;
      shamt_mem[wr_ptr] <= wr_shamt;
    end
  end

endmodule

// ==== alu_decode.sv ====
`timescale 1ns/1ps

module alu_decode (
  input  logic             clk,
  input  logic             reset_n,
  input  logic             in_valid,
  output logic             in_ready,
  input  isa_pkg::instr_t  instr,
  input  alu_pkg::word_t   rs_val,
  input  alu_pkg::word_t   rt_val,
  output logic             dec_valid,
  input  logic             dec_ready,
  output alu_pkg::alu_op_e dec_op,
  output alu_pkg::word_t   dec_a,
  output alu_pkg::word_t   dec_b,
  output alu_pkg::shamt_t  dec_shamt
);

  import isa_pkg::*;
  import alu_pkg::*;

  opcode_t    opcode;
  funct_t     funct;
  logic [4:0] rt_sel;
  logic [15:0] imm;
  alu_op_e    op_next;
  logic       use_imm;   // Operand b from the immediate
  logic       imm_zext;  // Logic forms and LUI zero-extend
  word_t      b_next;
  logic       run;       // Low for the first cycle out of reset
  logic       in_fire;

  assign opcode = instr[31:26];
  assign funct  = instr[5:0];
  assign rt_sel = instr[20:16];
  assign imm    = instr[15:0];

  // Stage refills on the same edge it drains
  assign in_ready = run && (!dec_valid || dec_ready);
  assign in_fire  = in_valid && in_ready;

  always_comb begin
    op_next  = OP_ILLEGAL;
    use_imm  = 1'b0;
    imm_zext = 1'b0;
    case (opcode)
      OPC_SPECIAL: begin
        case (funct)
          FN_SLL:   op_next = OP_SLL;
          FN_SRL:   op_next = OP_SRL;
          FN_SRA:   op_next = OP_SRA;
          FN_SLLV:  op_next = OP_SLLV;
          FN_SRLV:  op_next = OP_SRLV;
          FN_SRAV:  op_next = OP_SRAV;
          FN_JR,
          FN_JALR:  op_next = OP_JR;
          FN_MFHI:  op_next = OP_MFHI;
          FN_MTHI:  op_next = OP_MTHI;
          FN_MFLO:  op_next = OP_MFLO;
          FN_MTLO:  op_next = OP_MTLO;
          FN_MULT:  op_next = OP_MULT;
          FN_MULTU: op_next = OP_MULTU;
          FN_DIV:   op_next = OP_DIV;
          FN_DIVU:  op_next = OP_DIVU;
          FN_ADDU:  op_next = OP_ADDU;
          FN_SUBU:  op_next = OP_SUBU;
          FN_AND:   op_next = OP_AND;
          FN_OR:    op_next = OP_OR;
          FN_XOR:   op_next = OP_XOR;
          FN_SLT:   op_next = OP_SLT;
          FN_SLTU:  op_next = OP_SLTU;
          default:  op_next = OP_ILLEGAL;
        endcase
      end
      OPC_REGIMM: begin
        if (rt_sel == RT_BLTZ) op_next = OP_BLTZ;
        else if (rt_sel == RT_BGEZ) op_next = OP_BGEZ;
      end
      // BEQ travels as OP_BNE and the user reads zero inverted
      OPC_BEQ,
      OPC_BNE:   op_next = OP_BNE;
      OPC_BLEZ:  op_next = OP_BLEZ;
      OPC_BGTZ:  op_next = OP_BGTZ;
      OPC_ADDIU: begin op_next = OP_ADDU; use_imm = 1'b1; end
      OPC_SLTI:  begin op_next = OP_SLT;  use_imm = 1'b1; end
      OPC_SLTIU: begin op_next = OP_SLTU; use_imm = 1'b1; end
      OPC_ANDI:  begin op_next = OP_AND;  use_imm = 1'b1; imm_zext = 1'b1; end
      OPC_ORI:   begin op_next = OP_OR;   use_imm = 1'b1; imm_zext = 1'b1; end
      OPC_XORI:  begin op_next = OP_XOR;  use_imm = 1'b1; imm_zext = 1'b1; end
      OPC_LUI:   begin op_next = OP_LUI;  use_imm = 1'b1; imm_zext = 1'b1; end
      OPC_SB:    begin op_next = OP_SB;   use_imm = 1'b1; end  // Offset rides on b
      OPC_SH:    begin op_next = OP_SH;   use_imm = 1'b1; end
      default:   op_next = OP_ILLEGAL;
    endcase
  end

  always_comb begin
    if (!use_imm) b_next = rt_val;
    else if (imm_zext) b_next = {16'h0000, imm};
    else b_next = {{16{imm[15]}}, imm};
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      run       <= 1'b0;
      dec_valid <= 1'b0;
    end else begin
      run <= 1'b1;
      if (in_fire) dec_valid <= 1'b1;
      else if (dec_ready) dec_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      dec_op    <= op_next;
      dec_a     <= rs_val;
      dec_b     <= b_next;
      dec_shamt <= instr[10:6]; // Always the shamt field
    end
  end

endmodule

// ==== alu_pkg.sv ====
package alu_pkg;

  typedef logic [31:0] word_t;  // Operand and result word
  typedef logic [63:0] dword_t; // Full multiply product
  typedef logic [4:0]  shamt_t; // Shift amount

  // Fixed 5-bit ALU control codes
  typedef enum logic [4:0] {
    OP_AND     = 5'b00000,
    OP_OR      = 5'b00001,
    OP_XOR     = 5'b00010,
    OP_ADDU    = 5'b00011,
    OP_SUBU    = 5'b00100,
    OP_SLTU    = 5'b00101,
    OP_SLT     = 5'b00110,
    OP_MULTU   = 5'b00111,
    OP_MULT    = 5'b01000,
    OP_SLL     = 5'b01001,
    OP_SLLV    = 5'b01010,
    OP_SRA     = 5'b01011,
    OP_SRL     = 5'b01100,
    OP_SRAV    = 5'b01101,
    OP_SRLV    = 5'b01110,
    OP_DIV     = 5'b01111,
    OP_DIVU    = 5'b10000,
    OP_MTHI    = 5'b10001,
    OP_MTLO    = 5'b10010,
    OP_BLTZ    = 5'b10011,
    OP_BGTZ    = 5'b10100,
    OP_BGEZ    = 5'b10101,
    OP_BNE     = 5'b10110,
    OP_BLEZ    = 5'b10111,
    OP_JR      = 5'b11000,
    OP_LUI     = 5'b11001,
    OP_MFHI    = 5'b11010,
    OP_MFLO    = 5'b11011,
    OP_SB      = 5'b11100,
    OP_SH      = 5'b11101,
    OP_ILLEGAL = 5'b11111  // 5'b11110 stays unused
  } alu_op_e;

  localparam int FIFO_DEPTH = 4; // Decode to execute buffer entries

endpackage

// ==== isa_pkg.sv ====
package isa_pkg;

  typedef logic [31:0] instr_t;  // Raw instruction word
  typedef logic [5:0]  opcode_t; // instr[31:26]
  typedef logic [5:0]  funct_t;  // instr[5:0], R-type only

  // Major opcodes
  localparam opcode_t OPC_SPECIAL = 6'b000000;
  localparam opcode_t OPC_REGIMM  = 6'b000001;
  localparam opcode_t OPC_BEQ     = 6'b000100;
  localparam opcode_t OPC_BNE     = 6'b000101;
  localparam opcode_t OPC_BLEZ    = 6'b000110;
  localparam opcode_t OPC_BGTZ    = 6'b000111;
  localparam opcode_t OPC_ADDIU   = 6'b001001;
  localparam opcode_t OPC_SLTI    = 6'b001010;
  localparam opcode_t OPC_SLTIU   = 6'b001011;
  localparam opcode_t OPC_ANDI    = 6'b001100;
  localparam opcode_t OPC_ORI     = 6'b001101;
  localparam opcode_t OPC_XORI    = 6'b001110;
  localparam opcode_t OPC_LUI     = 6'b001111;
  localparam opcode_t OPC_SB      = 6'b101000;
  localparam opcode_t OPC_SH      = 6'b101001;

  // SPECIAL funct codes
  localparam funct_t FN_SLL   = 6'b000000;
  localparam funct_t FN_SRL   = 6'b000010;
  localparam funct_t FN_SRA   = 6'b000011;
  localparam funct_t FN_SLLV  = 6'b000100;
  localparam funct_t FN_SRLV  = 6'b000110;
  localparam funct_t FN_SRAV  = 6'b000111;
  localparam funct_t FN_JR    = 6'b001000;
  localparam funct_t FN_JALR  = 6'b001001;
  localparam funct_t FN_MFHI  = 6'b010000;
  localparam funct_t FN_MTHI  = 6'b010001;
  localparam funct_t FN_MFLO  = 6'b010010;
  localparam funct_t FN_MTLO  = 6'b010011;
  localparam funct_t FN_MULT  = 6'b011000;
  localparam funct_t FN_MULTU = 6'b011001;
  localparam funct_t FN_DIV   = 6'b011010;
  localparam funct_t FN_DIVU  = 6'b011011;
  localparam funct_t FN_ADDU  = 6'b100001;
  localparam funct_t FN_SUBU  = 6'b100011;
  localparam funct_t FN_AND   = 6'b100100;
  localparam funct_t FN_OR    = 6'b100101;
  localparam funct_t FN_XOR   = 6'b100110;
  localparam funct_t FN_SLT   = 6'b101010;
  localparam funct_t FN_SLTU  = 6'b101011;

  // REGIMM selectors in the rt field
  localparam logic [4:0] RT_BLTZ = 5'b00000;
  localparam logic [4:0] RT_BGEZ = 5'b00001;

endpackage
